// ==== compile.f ====
+incdir+.
simd_add_pkg.sv
cla_group8.sv
cla_adder64.sv
add_ingress_fifo.sv
add_exec_stage.sv
simd_adder_top.sv
tb_simd_adder.sv

// ==== run_sim.sh ====
#!/bin/sh
# Verilator build and run of the SIMD adder testbench

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --top-module tb_simd_adder -f compile.f -o sim_simd_adder
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_simd_adder > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^\*\*\* PASSED \*\*\*$' sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

// ==== tb_simd_adder.sv ====
`timescale 1ns/10ps

`include "simd_add_consts.svh"

module tb_simd_adder;

    localparam int SEED          = 32'hc4ff_7900;
    localparam int SEND_TIMEOUT  = 200;
    localparam int DRAIN_TIMEOUT = 2000;

    logic                    clk;
    logic                    rst;
    logic                    in_valid;
    simd_add_pkg::add_word_u in_a;
    simd_add_pkg::add_word_u in_b;
    simd_add_pkg::add_op_e   in_op;
    simd_add_pkg::add_mode_e in_mode;
    logic                    in_credit;
    logic                    out_credit;
    logic                    out_valid;
    simd_add_pkg::add_word_u out_sum;
    logic [1:0]              out_carry;

    // expected results, in send order
    simd_add_pkg::add_word_u exp_sum_q[$];
    logic [1:0]              exp_carry_q[$];

    int   sent;
    int   received;
    int   credit_pulses;
    int   unit_credits;
    int   owed;
    logic hold_credit;
    int   max_delay;
    int   seed;

    simd_adder_top UUT (
        .clk(clk), .rst(rst),
        .in_valid(in_valid), .in_a(in_a), .in_b(in_b), .in_op(in_op), .in_mode(in_mode),
        .in_credit(in_credit),
        .out_credit(out_credit), .out_valid(out_valid),
        .out_sum(out_sum), .out_carry(out_carry)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ****************************************
    // failure reporting and compares
    // ****************************************

    task automatic stop_with_failure();
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic report_error(input string msg);
        $display("ERROR at time %0t: %s", $time, msg);
        stop_with_failure();
    endtask

    task automatic check_sum(input simd_add_pkg::add_word_u got,
                             input simd_add_pkg::add_word_u exp, input int idx);
        if (got.word !== exp.word) begin
            $display("Mismatch at time %0t: item %0d sum got %h expected %h",
                     $time, idx, got.word, exp.word);
            stop_with_failure();
        end
    endtask

    task automatic check_carry(input logic [1:0] got, input logic [1:0] exp, input int idx);
        if (got !== exp) begin
            $display("Mismatch at time %0t: item %0d carry got %b expected %b",
                     $time, idx, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("Mismatch at time %0t: %s got %0d expected %0d", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    // two's complement reference, lane carries from 33-bit sums
    function automatic void reference_result(
        input  simd_add_pkg::add_word_u a,
        input  simd_add_pkg::add_word_u b,
        input  simd_add_pkg::add_op_e   op,
        input  simd_add_pkg::add_mode_e mode,
        output simd_add_pkg::add_word_u sum,
        output logic [1:0]              carry
    );
        logic [64:0] wide;
        logic [32:0] part;
        logic        sub;
        sub = (op == simd_add_pkg::ADD_OP_SUB);
        if (mode == simd_add_pkg::ADD_MODE_WIDE) begin
            wide     = sub ? {1'b0, a.word} - {1'b0, b.word} : {1'b0, a.word} + {1'b0, b.word};
            sum.word = wide[63:0];
            // for subtract the carry means no borrow
            carry    = {sub ? ~wide[64] : wide[64], 1'b0};
        end else begin
            for (int i = 0; i < 2; i++) begin
                part = sub ? {1'b0, a.lane[i]} - {1'b0, b.lane[i]}
                           : {1'b0, a.lane[i]} + {1'b0, b.lane[i]};
                sum.lane[i] = part[31:0];
                carry[i]    = sub ? ~part[32] : part[32];
            end
        end
    endfunction

    // ****************************************
    // credit models and monitor
    // ****************************************

    // sender credit return, taken on the edge that completes the pop
    initial begin : credit_counter
        credit_pulses = 0;
        forever begin
            @(posedge clk);
            if (!rst && in_credit) begin
                credit_pulses++;
            end
        end
    end

    initial begin : monitor
        int delay_cnt;
        int delay_seed;
        delay_cnt     = 0;
        delay_seed    = SEED;
        out_credit    = 1'b0;
        received      = 0;
        unit_credits  = `ADD_OUT_CREDITS;
        owed          = 0;
        forever begin
            @(negedge clk);
            out_credit = 1'b0;
            if (!rst) begin
                if (out_valid) begin
                    if (unit_credits == 0) begin
                        report_error("out_valid was raised while the unit held no credit");
                    end
                    if (received >= exp_sum_q.size()) begin
                        report_error("out_valid was raised with no item outstanding");
                    end
                    unit_credits--;
                    check_sum(out_sum, exp_sum_q[received], received);
                    check_carry(out_carry, exp_carry_q[received], received);
                    received++;
                    owed++;
                end
                // consumer hands credits back, one per cycle after a delay
                if (owed > 0 && !hold_credit) begin
                    if (delay_cnt == 0) begin
                        out_credit = 1'b1;
                        owed--;
                        unit_credits++;
                        delay_cnt = $unsigned($random(delay_seed)) % (max_delay + 1);
                    end else begin
                        delay_cnt--;
                    end
                end
            end
        end
    end

    // ****************************************
    // stimulus helpers
    // ****************************************

    task automatic send_item(input logic [63:0] a, input logic [63:0] b,
                             input simd_add_pkg::add_op_e op,
                             input simd_add_pkg::add_mode_e mode);
        simd_add_pkg::add_word_u exp_s;
        logic [1:0]              exp_c;
        int                      waited;
        waited = 0;
        @(negedge clk);
        while (`ADD_IN_DEPTH - sent + credit_pulses <= 0) begin
            in_valid = 1'b0;
            waited++;
            if (waited > SEND_TIMEOUT) begin
                report_error("no in_credit came back, the sender stayed out of credits");
            end
            @(negedge clk);
        end
        in_valid  = 1'b1;
        in_a.word = a;
        in_b.word = b;
        in_op     = op;
        in_mode   = mode;
        reference_result(in_a, in_b, op, mode, exp_s, exp_c);
        exp_sum_q.push_back(exp_s);
        exp_carry_q.push_back(exp_c);
        sent++;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        @(negedge clk);
        in_valid = 1'b0;
        while (received < sent) begin
            waited++;
            if (waited > DRAIN_TIMEOUT) begin
                report_error("results stopped arriving before every item came out");
            end
            @(negedge clk);
        end
    endtask

    // ****************************************
    // directed tests
    // ****************************************

    task automatic test_reset_idle();
        for (int cyc = 0; cyc < 6; cyc++) begin
            @(negedge clk);
            check_count(int'(in_credit), 0, "in_credit while idle");
            check_count(int'(out_valid), 0, "out_valid while idle");
        end
        send_item(64'd5, 64'd9, simd_add_pkg::ADD_OP_ADD, simd_add_pkg::ADD_MODE_WIDE);
        wait_drain();
        check_count(credit_pulses, 1, "in_credit pulses for one item");
    endtask

    task automatic test_wide_add();
        send_item('1, 64'd1, simd_add_pkg::ADD_OP_ADD, simd_add_pkg::ADD_MODE_WIDE);
        send_item(64'h0000_0000_ffff_ffff, 64'd1, simd_add_pkg::ADD_OP_ADD,
                  simd_add_pkg::ADD_MODE_WIDE);
        send_item(64'h1234_5678_9abc_def0, 64'h0fed_cba9_8765_4321, simd_add_pkg::ADD_OP_ADD,
                  simd_add_pkg::ADD_MODE_WIDE);
        wait_drain();
    endtask

    task automatic test_wide_sub();
        send_item(64'd100, 64'd7, simd_add_pkg::ADD_OP_SUB, simd_add_pkg::ADD_MODE_WIDE);
        send_item(64'd7, 64'd100, simd_add_pkg::ADD_OP_SUB, simd_add_pkg::ADD_MODE_WIDE);
        send_item(64'h8000_0000_0000_0001, 64'h8000_0000_0000_0001, simd_add_pkg::ADD_OP_SUB,
                  simd_add_pkg::ADD_MODE_WIDE);
        send_item(64'd0, 64'd1, simd_add_pkg::ADD_OP_SUB, simd_add_pkg::ADD_MODE_WIDE);
        wait_drain();
    endtask

    task automatic test_lane_mode();
        send_item('1, 64'd1, simd_add_pkg::ADD_OP_ADD, simd_add_pkg::ADD_MODE_LANE);
        send_item(64'h0000_0001_ffff_ffff, 64'd1, simd_add_pkg::ADD_OP_ADD,
                  simd_add_pkg::ADD_MODE_LANE);
        send_item(64'h0000_0005_0000_0003, 64'h0000_0007_0000_0001, simd_add_pkg::ADD_OP_SUB,
                  simd_add_pkg::ADD_MODE_LANE);
        send_item(64'h0000_0000_0000_0000, 64'h0000_0000_0000_0001, simd_add_pkg::ADD_OP_SUB,
                  simd_add_pkg::ADD_MODE_LANE);
        wait_drain();
    endtask

    task automatic test_backpressure();
        int start_sent;
        int start_recv;
        int start_pulses;
        repeat (2) @(negedge clk);
        start_sent   = sent;
        start_recv   = received;
        start_pulses = credit_pulses;
        hold_credit  = 1'b1;
        for (int cyc = 0; cyc < 24; cyc++) begin
            if (`ADD_IN_DEPTH - sent + credit_pulses > 0) begin
                send_item({32'h0bad_0000, 32'(cyc)}, 64'(cyc * 3), simd_add_pkg::ADD_OP_ADD,
                          simd_add_pkg::ADD_MODE_WIDE);
            end else begin
                @(negedge clk);
                in_valid = 1'b0;
            end
        end
        @(negedge clk);
        in_valid = 1'b0;
        check_count(sent - start_sent, `ADD_IN_DEPTH + 1 + `ADD_OUT_CREDITS,
                    "items accepted before the sender stalled");
        check_count(received - start_recv, `ADD_OUT_CREDITS, "results sent while credits held");
        hold_credit = 1'b0;
        wait_drain();
        check_count(credit_pulses - start_pulses, sent - start_sent, "in_credit pulses for burst");
    endtask

    task automatic test_random_mix();
        logic [31:0] bits;
        max_delay = 3;
        for (int n = 0; n < 200; n++) begin
            bits = $random(seed);
            send_item({$random(seed), $random(seed)}, {$random(seed), $random(seed)},
                      bits[0] ? simd_add_pkg::ADD_OP_SUB : simd_add_pkg::ADD_OP_ADD,
                      bits[1] ? simd_add_pkg::ADD_MODE_LANE : simd_add_pkg::ADD_MODE_WIDE);
        end
        wait_drain();
        check_count(credit_pulses, sent, "total in_credit pulses");
    endtask

    initial begin
        rst         = 1'b1;
        in_valid    = 1'b0;
        in_a        = '0;
        in_b        = '0;
        in_op       = simd_add_pkg::ADD_OP_ADD;
        in_mode     = simd_add_pkg::ADD_MODE_WIDE;
        sent        = 0;
        hold_credit = 1'b0;
        max_delay   = 0;
        seed        = SEED;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        test_reset_idle();
        test_wide_add();
        test_wide_sub();
        test_lane_mode();
        test_backpressure();
        test_random_mix();
        @(negedge clk);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== simd_adder_top.sv ====
`timescale 1ns/10ps

`include "simd_add_consts.svh"

module simd_adder_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_valid,
    input  simd_add_pkg::add_word_u in_a,
    input  simd_add_pkg::add_word_u in_b,
    input  simd_add_pkg::add_op_e   in_op,
    input  simd_add_pkg::add_mode_e in_mode,
    output logic                    in_credit,
    input  logic                    out_credit,
    output logic                    out_valid,
    output simd_add_pkg::add_word_u out_sum,
    output logic [1:0]              out_carry
);

    logic                    q_valid;
    logic                    q_pop;
    simd_add_pkg::add_word_u q_a;
    simd_add_pkg::add_word_u q_b;
    simd_add_pkg::add_op_e   q_op;
    simd_add_pkg::add_mode_e q_mode;

    add_ingress_fifo #(
        .DEPTH (`ADD_IN_DEPTH),
        .PTR_W (`ADD_IN_PTR_W)
    ) u_fifo (
        .clk(clk), .rst(rst),
        .in_valid(in_valid), .in_a(in_a), .in_b(in_b), .in_op(in_op), .in_mode(in_mode),
        .q_pop(q_pop), .q_valid(q_valid),
        .q_a(q_a), .q_b(q_b), .q_op(q_op), .q_mode(q_mode),
        .in_credit(in_credit)
    );

    add_exec_stage #(
        .CREDITS  (`ADD_OUT_CREDITS),
        .CREDIT_W (`ADD_CREDIT_W)
    ) u_exec (
        .clk(clk), .rst(rst),
        .q_valid(q_valid), .q_a(q_a), .q_b(q_b), .q_op(q_op), .q_mode(q_mode),
        .q_pop(q_pop),
        .out_credit(out_credit), .out_valid(out_valid),
        .out_sum(out_sum), .out_carry(out_carry)
    );

endmodule

// ==== add_exec_stage.sv ====
`timescale 1ns/10ps

`include "simd_add_consts.svh"

module add_exec_stage #(
    parameter int CREDITS  = `ADD_OUT_CREDITS,
    parameter int CREDIT_W = `ADD_CREDIT_W
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      q_valid,
    input  simd_add_pkg::add_word_u   q_a,
    input  simd_add_pkg::add_word_u   q_b,
    input  simd_add_pkg::add_op_e     q_op,
    input  simd_add_pkg::add_mode_e   q_mode,
    output logic                      q_pop,
    input  logic                      out_credit,
    output logic                      out_valid,
    output simd_add_pkg::add_word_u   out_sum,
    output logic [1:0]                out_carry
);

    simd_add_pkg::add_word_u b_eff;
    simd_add_pkg::add_word_u add_sum;
    logic [1:0]              add_carry;
    logic                    is_sub;
    logic                    lane_split;
    logic                    res_full;
    logic [CREDIT_W-1:0]     credit_cnt;

    // ****************************************
    // operation decode
    // ****************************************

    // subtract is a + ~b + 1 in each lane
    assign is_sub     = (q_op == simd_add_pkg::ADD_OP_SUB);
    assign lane_split = (q_mode == simd_add_pkg::ADD_MODE_LANE);
    assign b_eff.word = is_sub ? ~q_b.word : q_b.word;

    cla_adder64 u_adder (
        .a          (q_a),
        .b          (b_eff),
        .cin_lo     (is_sub),
        .cin_hi     (is_sub),
        .lane_split (lane_split),
        .sum        (add_sum),
        .carry      (add_carry)
    );

    // ****************************************
    // result register and output credits
    // ****************************************

    assign out_valid = res_full & (credit_cnt != '0);

    // refill when empty or emptying this cycle
    assign q_pop = q_valid & (~res_full | out_valid);

    always_ff @(posedge clk) begin
        if (rst) begin
            res_full <= 1'b0;
        end else if (q_pop) begin
            res_full <= 1'b1;
        end else if (out_valid) begin
            res_full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (q_pop) begin
            out_sum   <= add_sum;
            out_carry <= add_carry;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            credit_cnt <= CREDIT_W'(CREDITS);
        end else begin
            case ({out_valid, out_credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

endmodule

// ==== add_ingress_fifo.sv ====
`timescale 1ns/10ps

`include "simd_add_consts.svh"

module add_ingress_fifo #(
    parameter int DEPTH = `ADD_IN_DEPTH,
    parameter int PTR_W = `ADD_IN_PTR_W
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      in_valid,
    input  simd_add_pkg::add_word_u   in_a,
    input  simd_add_pkg::add_word_u   in_b,
    input  simd_add_pkg::add_op_e     in_op,
    input  simd_add_pkg::add_mode_e   in_mode,
    input  logic                      q_pop,
    output logic                      q_valid,
    output simd_add_pkg::add_word_u   q_a,
    output simd_add_pkg::add_word_u   q_b,
    output simd_add_pkg::add_op_e     q_op,
    output simd_add_pkg::add_mode_e   q_mode,
    output logic                      in_credit
);

    simd_add_pkg::add_word_u mem_a    [DEPTH];
    simd_add_pkg::add_word_u mem_b    [DEPTH];
    simd_add_pkg::add_op_e   mem_op   [DEPTH];
    simd_add_pkg::add_mode_e mem_mode [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             pop;

    // sender only pushes while holding a credit, so no full check here
    assign q_valid = (count != '0);
    assign pop     = q_pop & q_valid;

    // ****************************************
    // storage and pointers
    // ****************************************

    always_ff @(posedge clk) begin
        if (in_valid) begin
            mem_a[wr_ptr]    <= in_a;
            mem_b[wr_ptr]    <= in_b;
            mem_op[wr_ptr]   <= in_op;
            mem_mode[wr_ptr] <= in_mode;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (in_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + (PTR_W + 1)'(in_valid) - (PTR_W + 1)'(pop);
        end
    end

    assign q_a    = mem_a[rd_ptr];
    assign q_b    = mem_b[rd_ptr];
    assign q_op   = mem_op[rd_ptr];
    assign q_mode = mem_mode[rd_ptr];

    // credit goes back in the pop cycle, pop depends on flops only
    assign in_credit = pop;

endmodule

// ==== cla_adder64.sv ====
`timescale 1ns/10ps

module cla_adder64 (
    input  simd_add_pkg::add_word_u a,
    input  simd_add_pkg::add_word_u b,
    input  logic                    cin_lo,
    input  logic                    cin_hi,
    input  logic                    lane_split,
    output simd_add_pkg::add_word_u sum,
    output logic [1:0]              carry
);

    logic [63:0] s;
    logic        gc0, gc1, gc2, gc3, gc4, gc5, gc6, gc7;
    logic        cin4;

    // low lane, groups 0 to 3
    cla_group8 u_grp0 (.a(a.word[7:0]),   .b(b.word[7:0]),   .cin(cin_lo), .sum(s[7:0]),
                       .cout(gc0));
    cla_group8 u_grp1 (.a(a.word[15:8]),  .b(b.word[15:8]),  .cin(gc0),    .sum(s[15:8]),
                       .cout(gc1));
    cla_group8 u_grp2 (.a(a.word[23:16]), .b(b.word[23:16]), .cin(gc1),    .sum(s[23:16]),
                       .cout(gc2));
    cla_group8 u_grp3 (.a(a.word[31:24]), .b(b.word[31:24]), .cin(gc2),    .sum(s[31:24]),
                       .cout(gc3));

    // lane cut, carry stops at bit 32 when split
    assign cin4 = lane_split ? cin_hi : gc3;

    // high lane, groups 4 to 7
    cla_group8 u_grp4 (.a(a.word[39:32]), .b(b.word[39:32]), .cin(cin4),   .sum(s[39:32]),
                       .cout(gc4));
    cla_group8 u_grp5 (.a(a.word[47:40]), .b(b.word[47:40]), .cin(gc4),    .sum(s[47:40]),
                       .cout(gc5));
    cla_group8 u_grp6 (.a(a.word[55:48]), .b(b.word[55:48]), .cin(gc5),    .sum(s[55:48]),
                       .cout(gc6));
    cla_group8 u_grp7 (.a(a.word[63:56]), .b(b.word[63:56]), .cin(gc6),    .sum(s[63:56]),
                       .cout(gc7));

    assign sum.word = s;

    // low lane carry only reported in split mode
    assign carry[1] = gc7;
    assign carry[0] = lane_split & gc3;

endmodule

// ==== cla_group8.sv ====
`timescale 1ns/10ps

module cla_group8 (
    input  logic [7:0] a,
    input  logic [7:0] b,
    input  logic       cin,
    output logic [7:0] sum,
    output logic       cout
);

    logic [7:0] p;
    logic [7:0] g;
    logic [7:0] aoi_gp;
    logic [6:0] nand_pp;
    logic       c0, c1, c2, c3, c4, c5, c6, c7;

    assign p = a ^ b;
    assign g = a & b;

    // ****************************************
    // inverted pair terms
    // ****************************************

    // aoi stage, bit 0 pairs with the group carry-in
    assign aoi_gp[0]   = ~((p[0] & cin) | g[0]);
    assign aoi_gp[7:1] = ~((p[7:1] & g[6:0]) | g[7:1]);

    // nand of neighboring propagates
    assign nand_pp = ~(p[7:1] & p[6:0]);

    // oai stage, each carry reaches back two bits
    assign c0 = ~aoi_gp[0];
    assign c1 = ~((nand_pp[0] | ~cin) & aoi_gp[1]);
    assign c2 = ~((nand_pp[1] | ~c0) & aoi_gp[2]);
    assign c3 = ~((nand_pp[2] | ~c1) & aoi_gp[3]);
    assign c4 = ~((nand_pp[3] | ~c2) & aoi_gp[4]);
    assign c5 = ~((nand_pp[4] | ~c3) & aoi_gp[5]);
    assign c6 = ~((nand_pp[5] | ~c4) & aoi_gp[6]);
    assign c7 = ~((nand_pp[6] | ~c5) & aoi_gp[7]);

    assign sum  = p ^ {c6, c5, c4, c3, c2, c1, c0, cin};
    assign cout = c7;

endmodule

// ==== simd_add_pkg.sv ====
package simd_add_pkg;

    // operation select carried with each operand pair
    typedef enum logic {
        ADD_OP_ADD = 1'b0,
        ADD_OP_SUB = 1'b1
    } add_op_e;

    // one 64-bit word or two independent 32-bit lanes
    typedef enum logic {
        ADD_MODE_WIDE = 1'b0,
        ADD_MODE_LANE = 1'b1
    } add_mode_e;

    // ****************************************
    // operand and result word
    // ****************************************

    // lane[0] is the low half of word
    typedef union packed {
        logic [63:0]      word;
        logic [1:0][31:0] lane;
    } add_word_u;

endpackage

// ==== simd_add_consts.svh ====
`ifndef SIMD_ADD_CONSTS_SVH
`define SIMD_ADD_CONSTS_SVH

// input queue entries, also the sender's starting credits
`define ADD_IN_DEPTH 4

// input queue pointer width
`define ADD_IN_PTR_W 2

// credits the consumer grants at reset
`define ADD_OUT_CREDITS 2

// output credit counter width
`define ADD_CREDIT_W 2

`endif
